//--- logic/vdp_regs_pkg.sv
// VDP register definitions
// Register numbers, control register fields and screen mode encoding
`default_nettype none

package vdp_regs_pkg;

    typedef logic [5:0] reg_num_t;
    typedef logic [7:0] reg_data_t;

    // Register numbers owned by this block
    localparam reg_num_t R_MODE0     = 6'd0;
    localparam reg_num_t R_MODE1     = 6'd1;
    localparam reg_num_t R_NAME      = 6'd2;
    localparam reg_num_t R_COLOR     = 6'd7;
    localparam reg_num_t R_MODE2     = 6'd8;
    localparam reg_num_t R_MODE3     = 6'd9;
    localparam reg_num_t R_STAT_SEL  = 6'd15;
    localparam reg_num_t R_PAL_SEL   = 6'd16;
    localparam reg_num_t R_IND_SEL   = 6'd17;
    localparam reg_num_t R_HINT_LINE = 6'd19;

    typedef enum logic [3:0] {
        MODE_NONE,
        TEXT1, TEXT1Q, TEXT2,
        MULTI, MULTIQ,
        GRAPHIC1, GRAPHIC2, GRAPHIC3, GRAPHIC4,
        GRAPHIC5, GRAPHIC6, GRAPHIC7
    } screen_mode_e;

    // Control register fields seen by the display side
    typedef struct packed {
        logic       r0_hsync_int_en;
        logic       r1_sp_size;
        logic       r1_sp_zoom;
        logic       r1_bl_clks;
        logic       r1_vsync_int_en;
        logic       r1_disp_on;
        logic [6:0] r2_pt_nam_addr;
        reg_data_t  r7_frame_col;
        logic       r8_sp_off;
        logic       r8_col0_on;
        logic       r9_pal_mode;
        logic       r9_interlace_mode;
        logic       r9_y_dots;
        reg_data_t  r19_hsync_int_line;
    } ctrl_regs_t;

    typedef struct packed {
        screen_mode_e screen;
        logic         is_high_res;
        logic         sp_mode2;
        logic         vram_interleave;
    } mode_flags_t;

endpackage

`default_nettype wire

//--- logic/vdp_bus_pkg.sv
// VDP host bus definitions
// CPU request, register write, status input and palette types
`default_nettype none

package vdp_bus_pkg;

    import vdp_regs_pkg::*;

    typedef logic [1:0] port_t;
    typedef logic [3:0] pal_idx_t;
    typedef logic [1:0] dot_state_t;

    localparam port_t P_VRAM = 2'd0;
    localparam port_t P_CTRL = 2'd1;
    localparam port_t P_PAL  = 2'd2;
    localparam port_t P_IND  = 2'd3;

    typedef struct packed {
        logic      req;
        logic      wrt;
        port_t     adr;
        reg_data_t dbo;
    } cpu_req_t;

    // One register write, valid for a single cycle
    typedef struct packed {
        logic      valid;
        reg_num_t  num;
        reg_data_t data;
    } reg_wr_t;

    typedef struct packed {
        logic       vsync_int_n;
        logic       hsync_int_n;
        logic       sp_collision;
        logic       sp_over;
        logic [4:0] sp_over_num;
        logic       tr;
        logic       vd;
        logic       hd;
        logic       bd;
        logic       field;
        logic       ce;
        logic [4:0] vdp_id;
    } status_in_t;

    typedef struct packed {
        reg_data_t rb;
        reg_data_t g;
    } pal_entry_t;

endpackage

`default_nettype wire

//--- logic/cpu_port_decoder.sv
// Host port decoder
// Turns port requests into register writes, status read events and palette bytes
`timescale 1ns/1ps
`default_nettype none

module cpu_port_decoder
    import vdp_regs_pkg::*;
    import vdp_bus_pkg::*;
(
    input  logic      CLK21M,
    input  logic      RESET,
    input  cpu_req_t  bus,
    output logic      ack,
    output reg_wr_t   reg_wr,
    output logic      stat_rd,
    output logic      pal_byte_valid,
    output reg_data_t pal_byte
);

    typedef enum logic {
        FIRST,
        SECOND
    } byte_phase_e;

    byte_phase_e phase;
    reg_data_t   p1_first;
    logic        wr_pend;
    reg_num_t    wr_num;
    reg_data_t   wr_data;
    reg_num_t    ind_ptr;
    logic        ind_inc;
    logic        bus_rd;
    logic        bus_wr;

    assign bus_rd = bus.req & ~bus.wrt;
    assign bus_wr = bus.req & bus.wrt;

    assign stat_rd        = bus_rd && (bus.adr == P_CTRL);
    assign pal_byte_valid = bus_wr && (bus.adr == P_PAL);
    assign pal_byte       = bus.dbo;

    // A queued write goes out on the first idle bus cycle
    assign reg_wr = '{valid: wr_pend & ~bus.req, num: wr_num, data: wr_data};

    always_ff @(posedge CLK21M or posedge RESET) begin
        if (RESET) begin
            ack     <= 1'b0;
            phase   <= FIRST;
            wr_pend <= 1'b0;
            ind_ptr <= '0;
            ind_inc <= 1'b0;
        end else begin
            ack <= bus.req;
            if (stat_rd) begin
                phase <= FIRST;
            end else if (bus_wr && bus.adr == P_CTRL) begin
                if (phase == FIRST) begin
                    phase <= SECOND;
                end else begin
                    phase <= FIRST;
                    // Bit 7 clear would be a VRAM address setup
                    if (bus.dbo[7]) begin
                        wr_pend <= 1'b1;
                    end
                end
            end else if (bus_wr && bus.adr == P_IND) begin
                // R17 itself is protected from indirect writes
                if (ind_ptr != R_IND_SEL) begin
                    wr_pend <= 1'b1;
                end
                if (ind_inc) begin
                    ind_ptr <= ind_ptr + 6'd1;
                end
            end else if (reg_wr.valid) begin
                wr_pend <= 1'b0;
                if (reg_wr.num == R_IND_SEL) begin
                    ind_ptr <= reg_wr.data[5:0];
                    ind_inc <= ~reg_wr.data[7];
                end
            end
        end
    end

    // Byte buffers for the pending write
    always_ff @(posedge CLK21M) begin
        if (bus_wr && bus.adr == P_CTRL) begin
            if (phase == FIRST) begin
                p1_first <= bus.dbo;
            end else begin
                wr_num  <= bus.dbo[5:0];
                wr_data <= p1_first;
            end
        end else if (bus_wr && bus.adr == P_IND) begin
            wr_num  <= ind_ptr;
            wr_data <= bus.dbo;
        end
    end

endmodule

`default_nettype wire

//--- logic/control_regs.sv
// Control register bank
// Holds R0-R9 and R19, latches display mode on HSYNC and decodes the screen mode
`timescale 1ns/1ps
`default_nettype none

module control_regs
    import vdp_regs_pkg::*;
    import vdp_bus_pkg::*;
(
    input  logic        CLK21M,
    input  logic        RESET,
    input  reg_wr_t     reg_wr,
    input  logic        hsync,
    input  logic        forced_v_mode,
    output ctrl_regs_t  regs,
    output mode_flags_t mode
);

    logic [3:1] r0_mode_pend;
    logic [4:3] r1_mode_pend;
    logic       disp_on_pend;
    logic [3:1] r0_mode;
    logic [4:3] r1_mode;
    logic [4:0] mode_key;

    always_ff @(posedge CLK21M or posedge RESET) begin
        if (RESET) begin
            regs             <= '0;
            regs.r9_pal_mode <= forced_v_mode;
            r0_mode_pend     <= '0;
            r1_mode_pend     <= '0;
            disp_on_pend     <= 1'b0;
            r0_mode          <= '0;
            r1_mode          <= '0;
        end else begin
            if (reg_wr.valid) begin
                case (reg_wr.num)
                    R_MODE0: begin
                        r0_mode_pend         <= reg_wr.data[3:1];
                        regs.r0_hsync_int_en <= reg_wr.data[4];
                    end
                    R_MODE1: begin
                        regs.r1_sp_zoom      <= reg_wr.data[0];
                        regs.r1_sp_size      <= reg_wr.data[1];
                        regs.r1_bl_clks      <= reg_wr.data[2];
                        r1_mode_pend         <= reg_wr.data[4:3];
                        regs.r1_vsync_int_en <= reg_wr.data[5];
                        disp_on_pend         <= reg_wr.data[6];
                    end
                    R_NAME: begin
                        regs.r2_pt_nam_addr <= reg_wr.data[6:0];
                    end
                    R_COLOR: begin
                        regs.r7_frame_col <= reg_wr.data;
                    end
                    R_MODE2: begin
                        regs.r8_sp_off  <= reg_wr.data[1];
                        regs.r8_col0_on <= reg_wr.data[5];
                    end
                    R_MODE3: begin
                        regs.r9_pal_mode       <= reg_wr.data[1];
                        regs.r9_interlace_mode <= reg_wr.data[3];
                        regs.r9_y_dots         <= reg_wr.data[7];
                    end
                    R_HINT_LINE: begin
                        regs.r19_hsync_int_line <= reg_wr.data;
                    end
                    default: begin
                    end
                endcase
            end
            // Mode changes only take effect at a line boundary
            if (hsync) begin
                r0_mode         <= r0_mode_pend;
                r1_mode         <= r1_mode_pend;
                regs.r1_disp_on <= disp_on_pend;
            end
        end
    end

    // M5 M4 M3 then M2 M1
    assign mode_key = {r0_mode, r1_mode[3], r1_mode[4]};

    always_comb begin
        case (mode_key)
            5'b00000: mode.screen = GRAPHIC1;
            5'b00001: mode.screen = TEXT1;
            5'b00010: mode.screen = MULTI;
            5'b00100: mode.screen = GRAPHIC2;
            5'b00101: mode.screen = TEXT1Q;
            5'b00110: mode.screen = MULTIQ;
            5'b01000: mode.screen = GRAPHIC3;
            5'b01001: mode.screen = TEXT2;
            5'b01100: mode.screen = GRAPHIC4;
            5'b10000: mode.screen = GRAPHIC5;
            5'b10100: mode.screen = GRAPHIC6;
            5'b11100: mode.screen = GRAPHIC7;
            default:  mode.screen = MODE_NONE;
        endcase
        mode.is_high_res     = (r0_mode[3:2] == 2'b10) && (r1_mode == 2'b00);
        mode.sp_mode2        = (r1_mode == 2'b00) && (r0_mode[3] || r0_mode[2]);
        mode.vram_interleave = r0_mode[3] && r0_mode[1];
    end

endmodule

`default_nettype wire

//--- logic/status_reader.sv
// Status read path
// Returns S0-S2 on port 1 reads and raises the interrupt clear pulses
`timescale 1ns/1ps
`default_nettype none

module status_reader
    import vdp_regs_pkg::*;
    import vdp_bus_pkg::*;
(
    input  logic       CLK21M,
    input  logic       RESET,
    input  cpu_req_t   bus,
    input  logic       stat_rd,
    input  reg_wr_t    reg_wr,
    input  status_in_t status,
    output reg_data_t  dbi,
    output logic       clr_vsync_int,
    output logic       clr_hsync_int
);

    logic [3:0] stat_sel;
    logic       hint_wr;

    // R19 write, or R0 write enabling the line interrupt
    assign hint_wr = reg_wr.valid && ((reg_wr.num == R_HINT_LINE) ||
                     (reg_wr.num == R_MODE0 && reg_wr.data[4]));

    always_ff @(posedge CLK21M or posedge RESET) begin
        if (RESET) begin
            stat_sel      <= '0;
            dbi           <= '0;
            clr_vsync_int <= 1'b0;
            clr_hsync_int <= 1'b0;
        end else begin
            if (reg_wr.valid && reg_wr.num == R_STAT_SEL) begin
                stat_sel <= reg_wr.data[3:0];
            end
            if (bus.req && !bus.wrt) begin
                if (bus.adr == P_CTRL) begin
                    case (stat_sel)
                        4'd0: dbi <= {~status.vsync_int_n, status.sp_over,
                                      status.sp_collision, status.sp_over_num};
                        4'd1: dbi <= {2'b00, status.vdp_id, ~status.hsync_int_n};
                        4'd2: dbi <= {status.tr, status.vd, status.hd, status.bd,
                                      2'b11, status.field, status.ce};
                        default: dbi <= '0;
                    endcase
                end else begin
                    dbi <= '1;
                end
            end
            clr_vsync_int <= stat_rd && (stat_sel == 4'd0);
            clr_hsync_int <= (stat_rd && stat_sel == 4'd1) || hint_wr;
        end
    end

endmodule

`default_nettype wire

//--- logic/palette_writer.sv
// Palette writer
// Pairs the port 2 bytes and commits each entry in an odd dot state
`timescale 1ns/1ps
`default_nettype none

module palette_writer
    import vdp_regs_pkg::*;
    import vdp_bus_pkg::*;
(
    input  logic       CLK21M,
    input  logic       RESET,
    input  reg_wr_t    reg_wr,
    input  logic       pal_byte_valid,
    input  reg_data_t  pal_byte,
    input  dot_state_t dot_state,
    output logic       pal_we,
    output pal_idx_t   pal_wr_idx,
    output pal_entry_t pal_wr_data
);

    pal_idx_t  pal_num;
    logic      second_byte;
    reg_data_t rb_byte;
    logic      wr_req;
    logic      wr_ack;
    logic      odd_dot;

    // Display side leaves the palette free in states 01 and 10
    assign odd_dot = (dot_state == 2'b01) || (dot_state == 2'b10);

    always_ff @(posedge CLK21M or posedge RESET) begin
        if (RESET) begin
            pal_num     <= '0;
            second_byte <= 1'b0;
            wr_req      <= 1'b0;
            wr_ack      <= 1'b0;
            pal_we      <= 1'b0;
        end else begin
            if (reg_wr.valid && reg_wr.num == R_PAL_SEL) begin
                pal_num     <= reg_wr.data[3:0];
                second_byte <= 1'b0;
            end else if (pal_byte_valid) begin
                second_byte <= ~second_byte;
                if (second_byte) begin
                    wr_req  <= ~wr_ack;
                    pal_num <= pal_num + 4'd1;
                end
            end
            pal_we <= odd_dot && (wr_req != wr_ack);
            if (odd_dot && wr_req != wr_ack) begin
                wr_ack <= ~wr_ack;
            end
        end
    end

    // Entry is taken whole once green arrives
    always_ff @(posedge CLK21M) begin
        if (pal_byte_valid) begin
            if (!second_byte) begin
                rb_byte <= pal_byte;
            end else begin
                pal_wr_data <= '{rb: rb_byte, g: pal_byte};
                pal_wr_idx  <= pal_num;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/palette_bank.sv
// Palette RAM bank
// 16 by 8 single port RAM, write wins the shared address
`timescale 1ns/1ps
`default_nettype none

module palette_bank
    import vdp_regs_pkg::*;
    import vdp_bus_pkg::*;
(
    input  logic      CLK21M,
    input  logic      we,
    input  pal_idx_t  wr_idx,
    input  pal_idx_t  rd_idx,
    input  reg_data_t wdata,
    output reg_data_t rdata
);

    reg_data_t mem [16];
    pal_idx_t  adr;

    assign adr = we ? wr_idx : rd_idx;

    always_ff @(posedge CLK21M) begin
        if (we) begin
            mem[adr] <= wdata;
        end
        rdata <= mem[adr];
    end

endmodule

`default_nettype wire

//--- logic/vdp_register.sv
// VDP register block top level
// Host port decode, control and status registers, and the palette memory
`timescale 1ns/1ps
`default_nettype none

module vdp_register
    import vdp_regs_pkg::*;
    import vdp_bus_pkg::*;
(
    input  logic        CLK21M,
    input  logic        RESET,
    input  logic        req,
    input  logic        wrt,
    input  port_t       adr,
    input  reg_data_t   dbo,
    output logic        ack,
    output reg_data_t   dbi,
    input  dot_state_t  dot_state,
    input  logic        hsync,
    input  logic        forced_v_mode,
    input  status_in_t  status,
    output logic        clr_vsync_int,
    output logic        clr_hsync_int,
    output ctrl_regs_t  regs,
    output mode_flags_t mode,
    input  pal_idx_t    pal_rd_idx,
    output pal_entry_t  pal_rd_data
);

    cpu_req_t         bus;
    reg_wr_t          reg_wr;
    logic             stat_rd;
    logic             pal_byte_valid;
    reg_data_t        pal_byte;
    logic             pal_we;
    pal_idx_t         pal_wr_idx;
    pal_entry_t       pal_wr_data;
    reg_data_t [1:0]  wr_bytes;
    reg_data_t [1:0]  rd_bytes;

    assign bus = '{req: req, wrt: wrt, adr: adr, dbo: dbo};

    cpu_port_decoder u_decoder (
        .CLK21M(CLK21M), .RESET(RESET), .bus(bus), .ack(ack), .reg_wr(reg_wr),
        .stat_rd(stat_rd), .pal_byte_valid(pal_byte_valid), .pal_byte(pal_byte)
    );

    control_regs u_ctrl (
        .CLK21M(CLK21M), .RESET(RESET), .reg_wr(reg_wr), .hsync(hsync),
        .forced_v_mode(forced_v_mode), .regs(regs), .mode(mode)
    );

    status_reader u_status (
        .CLK21M(CLK21M), .RESET(RESET), .bus(bus), .stat_rd(stat_rd),
        .reg_wr(reg_wr), .status(status), .dbi(dbi),
        .clr_vsync_int(clr_vsync_int), .clr_hsync_int(clr_hsync_int)
    );

    palette_writer u_pal_wr (
        .CLK21M(CLK21M), .RESET(RESET), .reg_wr(reg_wr),
        .pal_byte_valid(pal_byte_valid), .pal_byte(pal_byte), .dot_state(dot_state),
        .pal_we(pal_we), .pal_wr_idx(pal_wr_idx), .pal_wr_data(pal_wr_data)
    );

    // Byte 1 is red-blue, byte 0 is green
    assign wr_bytes    = pal_wr_data;
    assign pal_rd_data = rd_bytes;

    for (genvar i = 0; i < 2; i++) begin : g_pal_bank
        palette_bank u_bank (
            .CLK21M(CLK21M), .we(pal_we), .wr_idx(pal_wr_idx), .rd_idx(pal_rd_idx),
            .wdata(wr_bytes[i]), .rdata(rd_bytes[i])
        );
    end

endmodule

`default_nettype wire

//--- sim/vdp_check_defs.svh
// Check selectors for the VDP register testbench
// Each code names one DUT observation that a table row compares

localparam logic [3:0] K_NONE  = 4'd0;
localparam logic [3:0] K_DBI   = 4'd1;
localparam logic [3:0] K_R0    = 4'd2;
localparam logic [3:0] K_R1    = 4'd3;
localparam logic [3:0] K_R2    = 4'd4;
localparam logic [3:0] K_R7    = 4'd5;
localparam logic [3:0] K_R8    = 4'd6;
localparam logic [3:0] K_R9    = 4'd7;
localparam logic [3:0] K_R19   = 4'd8;
localparam logic [3:0] K_MODE  = 4'd9;
// High-res, sprite mode 2 and VRAM interleave, MSB first
localparam logic [3:0] K_FLAGS = 4'd10;
// Clear pulse counts since power-up
localparam logic [3:0] K_VCLR  = 4'd11;
localparam logic [3:0] K_HCLR  = 4'd12;
localparam logic [3:0] K_PAL   = 4'd13;

//--- sim/vdp_checker.sv
// VDP register checker
// Samples DUT outputs on the falling edge and compares them on request
`timescale 1ns/1ps
`default_nettype none

module vdp_checker
    import vdp_regs_pkg::*;
    import vdp_bus_pkg::*;
(
    input  logic        CLK21M,
    input  logic        RESET,
    input  logic        ack,
    input  reg_data_t   dbi,
    input  ctrl_regs_t  regs,
    input  mode_flags_t mode,
    input  logic        clr_vsync_int,
    input  logic        clr_hsync_int,
    input  pal_entry_t  pal_rd_data,
    input  logic        chk_en,
    input  logic [3:0]  chk_kind,
    input  logic [15:0] chk_exp,
    output int          chk_cnt,
    output int          err_cnt
);

    `include "vdp_check_defs.svh"

    int          vclr_cnt;
    int          hclr_cnt;
    logic [15:0] got;

    // Register fields are put back at their bit positions in the register
    function automatic logic [15:0] observe(input logic [3:0] kind);
        case (kind)
            K_DBI:   return {8'h00, dbi};
            K_R0:    return {11'h000, regs.r0_hsync_int_en, 4'h0};
            K_R1:    return {8'h00, 1'b0, regs.r1_disp_on, regs.r1_vsync_int_en, 2'b00,
                             regs.r1_bl_clks, regs.r1_sp_size, regs.r1_sp_zoom};
            K_R2:    return {9'h000, regs.r2_pt_nam_addr};
            K_R7:    return {8'h00, regs.r7_frame_col};
            K_R8:    return {8'h00, 2'b00, regs.r8_col0_on, 3'b000, regs.r8_sp_off, 1'b0};
            K_R9:    return {8'h00, regs.r9_y_dots, 3'b000, regs.r9_interlace_mode, 1'b0,
                             regs.r9_pal_mode, 1'b0};
            K_R19:   return {8'h00, regs.r19_hsync_int_line};
            K_MODE:  return {12'h000, mode.screen};
            K_FLAGS: return {13'h0000, mode.is_high_res, mode.sp_mode2, mode.vram_interleave};
            K_VCLR:  return vclr_cnt[15:0];
            K_HCLR:  return hclr_cnt[15:0];
            K_PAL:   return pal_rd_data;
            default: return 16'h0000;
        endcase
    endfunction

    function automatic string kind_name(input logic [3:0] kind);
        case (kind)
            K_DBI:   return "read data";
            K_R0:    return "R0";
            K_R1:    return "R1";
            K_R2:    return "R2";
            K_R7:    return "R7";
            K_R8:    return "R8";
            K_R9:    return "R9";
            K_R19:   return "R19";
            K_MODE:  return "screen mode";
            K_FLAGS: return "mode flags";
            K_VCLR:  return "vsync clear count";
            K_HCLR:  return "hsync clear count";
            K_PAL:   return "palette entry";
            default: return "unknown field";
        endcase
    endfunction

    always @(negedge CLK21M) begin
        // Pulses are one cycle wide, so each one is seen exactly once here
        if (!RESET) begin
            if (clr_vsync_int) begin
                vclr_cnt++;
            end
            if (clr_hsync_int) begin
                hclr_cnt++;
            end
        end
        if (chk_en) begin
            chk_cnt++;
            got = observe(chk_kind);
            if (chk_kind == K_DBI && !ack) begin
                err_cnt++;
                $display("Read at %0t got no acknowledge from the DUT", $time);
            end else if (got !== chk_exp) begin
                err_cnt++;
                $display("Fail at %0t: %s is %h, expected %h", $time, kind_name(chk_kind),
                         got, chk_exp);
            end
        end
    end

endmodule

`default_nettype wire

//--- sim/tb_vdp_register.sv
// VDP register block testbench
// Applies a table of host port operations and checks through vdp_checker
`timescale 1ns/1ps
`default_nettype none

module tb_vdp_register
    import vdp_regs_pkg::*;
    import vdp_bus_pkg::*;
();

    `include "vdp_check_defs.svh"

    localparam int ACK_TIMEOUT = 20;

    typedef enum logic [2:0] {
        OP_WR,
        OP_RD,
        OP_HS,
        OP_PAL,
        OP_IDLE,
        OP_CHK
    } op_e;

    typedef struct packed {
        op_e         op;
        port_t       port;
        reg_data_t   data;
        logic [3:0]  kind;
        logic [15:0] exp;
    } step_t;

    logic        CLK21M = 1'b0;
    logic        RESET;
    logic        req;
    logic        wrt;
    port_t       adr;
    reg_data_t   dbo;
    logic        ack;
    reg_data_t   dbi;
    dot_state_t  dot_state;
    logic        hsync;
    logic        forced_v_mode;
    status_in_t  status;
    logic        clr_vsync_int;
    logic        clr_hsync_int;
    ctrl_regs_t  regs;
    mode_flags_t mode;
    pal_idx_t    pal_rd_idx;
    pal_entry_t  pal_rd_data;
    logic        chk_en;
    logic [3:0]  chk_kind;
    logic [15:0] chk_exp;
    int          chk_cnt;
    int          err_cnt;
    logic        timed_out;
    step_t       steps[$];

    vdp_register DUT (
        .CLK21M(CLK21M), .RESET(RESET), .req(req), .wrt(wrt), .adr(adr), .dbo(dbo),
        .ack(ack), .dbi(dbi), .dot_state(dot_state), .hsync(hsync),
        .forced_v_mode(forced_v_mode), .status(status), .clr_vsync_int(clr_vsync_int),
        .clr_hsync_int(clr_hsync_int), .regs(regs), .mode(mode),
        .pal_rd_idx(pal_rd_idx), .pal_rd_data(pal_rd_data)
    );

    vdp_checker u_checker (
        .CLK21M(CLK21M), .RESET(RESET), .ack(ack), .dbi(dbi), .regs(regs), .mode(mode),
        .clr_vsync_int(clr_vsync_int), .clr_hsync_int(clr_hsync_int),
        .pal_rd_data(pal_rd_data), .chk_en(chk_en), .chk_kind(chk_kind),
        .chk_exp(chk_exp), .chk_cnt(chk_cnt), .err_cnt(err_cnt)
    );

    always #5 CLK21M = ~CLK21M;

    // Dot clock phase runs freely 00, 01, 10, 11
    always @(posedge CLK21M) begin
        #1;
        dot_state <= dot_state + 2'd1;
    end

    function automatic void add_step(input op_e op, input port_t port, input reg_data_t data,
                                     input logic [3:0] kind, input logic [15:0] exp);
        steps.push_back('{op: op, port: port, data: data, kind: kind, exp: exp});
    endfunction

    function automatic void port_write(input port_t port, input reg_data_t data);
        add_step(OP_WR, port, data, K_NONE, 16'h0000);
    endfunction

    // Data byte first, then 10 and the register number
    function automatic void reg_write(input reg_num_t num, input reg_data_t data);
        port_write(P_CTRL, data);
        port_write(P_CTRL, {2'b10, num});
    endfunction

    function automatic void port_read(input port_t port, input logic [15:0] exp);
        add_step(OP_RD, port, 8'h00, K_DBI, exp);
    endfunction

    function automatic void hsync_pulse();
        add_step(OP_HS, P_VRAM, 8'h00, K_NONE, 16'h0000);
    endfunction

    function automatic void palette_lookup(input pal_idx_t idx, input logic [15:0] exp);
        add_step(OP_PAL, P_VRAM, {4'h0, idx}, K_PAL, exp);
    endfunction

    function automatic void idle_cycles(input reg_data_t n);
        add_step(OP_IDLE, P_VRAM, n, K_NONE, 16'h0000);
    endfunction

    function automatic void expect_field(input logic [3:0] kind, input logic [15:0] exp);
        add_step(OP_CHK, P_VRAM, 8'h00, kind, exp);
    endfunction

    function automatic void build_table();
        // Reset state, PAL bit follows forced_v_mode
        expect_field(K_R0, 16'h0000);
        expect_field(K_R1, 16'h0000);
        expect_field(K_R2, 16'h0000);
        expect_field(K_R7, 16'h0000);
        expect_field(K_R8, 16'h0000);
        expect_field(K_R9, 16'h0002);
        expect_field(K_R19, 16'h0000);
        expect_field(K_MODE, 16'(GRAPHIC1));
        // Two-byte writes on port 1
        reg_write(R_COLOR, 8'h5A);
        expect_field(K_R7, 16'h005A);
        reg_write(R_MODE1, 8'h63);
        // Display enable waits for the line boundary
        expect_field(K_R1, 16'h0023);
        hsync_pulse();
        expect_field(K_R1, 16'h0063);
        reg_write(R_MODE2, 8'h22);
        expect_field(K_R8, 16'h0022);
        // Name table address keeps 7 bits
        reg_write(R_NAME, 8'hFF);
        expect_field(K_R2, 16'h007F);
        // Status read restarts the byte pair, S0 = F, C and sprite number 0Ah
        port_write(P_CTRL, 8'h11);
        port_read(P_CTRL, 16'h00AA);
        reg_write(R_COLOR, 8'h44);
        expect_field(K_R7, 16'h0044);
        expect_field(K_VCLR, 16'd1);
        // Indirect writes with auto-increment from R7
        reg_write(R_IND_SEL, 8'h07);
        port_write(P_IND, 8'hF4);
        port_write(P_IND, 8'h20);
        port_write(P_IND, 8'h8A);
        expect_field(K_R7, 16'h00F4);
        expect_field(K_R8, 16'h0020);
        expect_field(K_R9, 16'h008A);
        // Pointer held on R19
        reg_write(R_IND_SEL, 8'h93);
        port_write(P_IND, 8'h40);
        port_write(P_IND, 8'h41);
        expect_field(K_R19, 16'h0041);
        expect_field(K_HCLR, 16'd2);
        // Write aimed at R17 is dropped and the pointer moves on to R18, R19
        reg_write(R_IND_SEL, 8'h11);
        port_write(P_IND, 8'h07);
        port_write(P_IND, 8'h00);
        port_write(P_IND, 8'h66);
        expect_field(K_R19, 16'h0066);
        expect_field(K_R7, 16'h00F4);
        expect_field(K_HCLR, 16'd3);
        // Screen modes change on HSYNC only
        reg_write(R_MODE1, 8'h10);
        expect_field(K_MODE, 16'(GRAPHIC1));
        hsync_pulse();
        expect_field(K_MODE, 16'(TEXT1));
        reg_write(R_MODE0, 8'h0E);
        reg_write(R_MODE1, 8'h00);
        expect_field(K_MODE, 16'(TEXT1));
        hsync_pulse();
        expect_field(K_MODE, 16'(GRAPHIC7));
        expect_field(K_FLAGS, 16'h0003);
        reg_write(R_MODE0, 8'h08);
        hsync_pulse();
        expect_field(K_MODE, 16'(GRAPHIC5));
        expect_field(K_FLAGS, 16'h0006);
        reg_write(R_MODE0, 8'h04);
        reg_write(R_MODE1, 8'h10);
        hsync_pulse();
        expect_field(K_MODE, 16'(TEXT2));
        // S1 holds ID 00010 and FH, S2 holds TR HD and field plus bits 3:2
        reg_write(R_STAT_SEL, 8'h01);
        port_read(P_CTRL, 16'h0005);
        expect_field(K_HCLR, 16'd4);
        reg_write(R_STAT_SEL, 8'h02);
        port_read(P_CTRL, 16'h00AE);
        reg_write(R_STAT_SEL, 8'h00);
        port_read(P_CTRL, 16'h00AA);
        expect_field(K_VCLR, 16'd2);
        reg_write(R_HINT_LINE, 8'h00);
        expect_field(K_HCLR, 16'd5);
        // Enabling the line interrupt in R0 also clears it
        reg_write(R_MODE0, 8'h10);
        expect_field(K_R0, 16'h0010);
        expect_field(K_HCLR, 16'd6);
        port_read(P_VRAM, 16'h00FF);
        port_read(P_IND, 16'h00FF);
        expect_field(K_VCLR, 16'd2);
        // Two palette entries from index 5
        reg_write(R_PAL_SEL, 8'h05);
        port_write(P_PAL, 8'h72);
        port_write(P_PAL, 8'h05);
        port_write(P_PAL, 8'h31);
        port_write(P_PAL, 8'h06);
        idle_cycles(8'd6);
        palette_lookup(4'd5, 16'h7205);
        palette_lookup(4'd6, 16'h3106);
    endfunction

    // One host cycle, then wait for the acknowledge
    task automatic bus_access(input logic is_write, input port_t port, input reg_data_t data);
        int waited;
        @(posedge CLK21M);
        #1;
        req = 1'b1;
        wrt = is_write;
        adr = port;
        dbo = data;
        @(posedge CLK21M);
        #1;
        req = 1'b0;
        wrt = 1'b0;
        waited = 0;
        while (!ack && waited < ACK_TIMEOUT) begin
            @(posedge CLK21M);
            #1;
            waited++;
        end
        if (!ack) begin
            timed_out = 1'b1;
            $display("Timeout: no acknowledge on port %0d within %0d cycles", port,
                     ACK_TIMEOUT);
        end
    endtask

    task automatic strobe_check(input logic [3:0] kind, input logic [15:0] expected);
        chk_kind = kind;
        chk_exp = expected;
        chk_en = 1'b1;
        @(posedge CLK21M);
        #1;
        chk_en = 1'b0;
    endtask

    task automatic run_step(input step_t s);
        case (s.op)
            OP_WR: begin
                bus_access(1'b1, s.port, s.data);
            end
            OP_RD: begin
                bus_access(1'b0, s.port, 8'h00);
                // Still in the ack cycle here
                if (!timed_out) begin
                    strobe_check(s.kind, s.exp);
                end
            end
            OP_HS: begin
                @(posedge CLK21M);
                #1;
                hsync = 1'b1;
                @(posedge CLK21M);
                #1;
                hsync = 1'b0;
            end
            OP_PAL: begin
                @(posedge CLK21M);
                #1;
                pal_rd_idx = s.data[3:0];
                @(posedge CLK21M);
                #1;
                strobe_check(s.kind, s.exp);
            end
            OP_IDLE: begin
                repeat (s.data) @(posedge CLK21M);
                #1;
            end
            default: begin
                @(posedge CLK21M);
                #1;
                strobe_check(s.kind, s.exp);
            end
        endcase
    endtask

    initial begin
        RESET = 1'b1;
        req = 1'b0;
        wrt = 1'b0;
        adr = P_VRAM;
        dbo = 8'h00;
        dot_state = 2'b00;
        hsync = 1'b0;
        forced_v_mode = 1'b1;
        // Interrupt lines active, collision and sprite 0Ah, TR HD and field set
        status = '{vsync_int_n: 1'b0, hsync_int_n: 1'b0, sp_collision: 1'b1,
                   sp_over: 1'b0, sp_over_num: 5'h0A, tr: 1'b1, vd: 1'b0, hd: 1'b1,
                   bd: 1'b0, field: 1'b1, ce: 1'b0, vdp_id: 5'b00010};
        pal_rd_idx = 4'd0;
        chk_en = 1'b0;
        chk_kind = K_NONE;
        chk_exp = 16'h0000;
        timed_out = 1'b0;
        build_table();
        repeat (2) @(posedge CLK21M);
        #1;
        RESET = 1'b0;
        for (int i = 0; i < steps.size() && !timed_out; i++) begin
            run_step(steps[i]);
        end
        repeat (2) @(posedge CLK21M);
        $display("Checks run: %0d, errors: %0d, timeouts: %0d", chk_cnt, err_cnt, timed_out);
        if (err_cnt == 0 && !timed_out) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vdp_register.f
+incdir+sim
logic/vdp_regs_pkg.sv
logic/vdp_bus_pkg.sv
logic/cpu_port_decoder.sv
logic/control_regs.sv
logic/status_reader.sv
logic/palette_writer.sv
logic/palette_bank.sv
logic/vdp_register.sv
sim/vdp_checker.sv
sim/tb_vdp_register.sv

//--- Makefile
# Verilator build and run of the VDP register block testbench

TOP := tb_vdp_register

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f vdp_register.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log
